//--- build.f
verilog/dt_core_pkg.sv
verilog/line_fifo.sv
verilog/core_fsm.sv
verilog/schedule_rotator.sv
verilog/distribution_tree.sv
verilog/result_gather.sv
verilog/dt_core.sv
testbench/tb_dt_core.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
	--top-module tb_dt_core -o tb_dt_core > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status, see build.log"
	exit 1
fi

./obj_dir/tb_dt_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Result: FAILED" sim.log; then
	exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
	echo "simulation ended without a verdict"
	exit 1
fi
exit 0

//--- testbench/tb_dt_core.sv
module tb_dt_core
	import dt_core_pkg::*;
;
	timeunit 1ns;
	timeprecision 100ps;

	// lines sent over all tests, used to size the watchdog
	localparam int N_LINES    = 44;
	localparam int LINE_BITS  = $bits(lane_line_t);
	localparam int PARAM_BITS = $bits(params_fields_t);

	logic                    clk = 1'b0;
	logic                    rst_n;
	logic                    start_core;
	core_line_t              din;
	logic                    din_valid;
	logic                    din_ready;
	core_cfg_t               cfg;
	lane_line_t              lane_out [NUM_CLUSTERS];
	logic [NUM_CLUSTERS-1:0] lane_ready;
	logic [RESULT_WIDTH-1:0] part_value [NUM_CLUSTERS];
	logic [NUM_CLUSTERS-1:0] part_valid;
	logic [NUM_CLUSTERS-1:0] part_ready;
	logic [RESULT_WIDTH-1:0] tuple_out_data;
	logic                    tuple_out_valid;
	logic                    tuple_out_ready;
	core_state_e             core_state;

	int unsigned             rng = 30;
	string                   test_name;
	int                      test_errs;
	int                      total_errs;
	int                      tests_ok;
	int                      tests_bad;
	lane_line_t              exp_lane [NUM_CLUSTERS][$];
	logic [RESULT_WIDTH-1:0] part_q [NUM_CLUSTERS][$];
	logic [RESULT_WIDTH-1:0] exp_result [$];
	logic [NUM_CLUSTERS-1:0] m_prog;
	logic [NUM_CLUSTERS-1:0] m_proc;
	int                      m_trees;
	logic [PU_BITS-1:0]      m_pu;
	int                      g_tuple;
	engine_params_t          ctrl_expect;
	bit                      hold_lanes;
	bit                      hold_result;
	bit                      stalled;
	bit                      held;
	logic [RESULT_WIDTH-1:0] held_data;
	logic [NUM_CLUSTERS-1:0] stall_ready;
	int                      hold_cycles;
	int                      ctrl_seen [NUM_CLUSTERS];

	dt_core uut (
		.clk                (clk),
		.rst_n              (rst_n),
		.start_core         (start_core),
		.core_data_in       (din),
		.core_data_in_valid (din_valid),
		.core_data_in_ready (din_ready),
		.cfg                (cfg),
		.lane_out           (lane_out),
		.lane_ready         (lane_ready),
		.part_value         (part_value),
		.part_valid         (part_valid),
		.part_ready         (part_ready),
		.tuple_out_data     (tuple_out_data),
		.tuple_out_valid    (tuple_out_valid),
		.tuple_out_ready    (tuple_out_ready),
		.core_state         (core_state)
	);

	always #4 clk = ~clk;

	////////////////////////////////
	// helpers and reference model
	////////////////////////////////

	function automatic int unsigned next_rand();
		rng ^= rng << 13;
		rng ^= rng >> 17;
		rng ^= rng << 5;
		return rng;
	endfunction

	function automatic logic [3:0] rotate_left(input logic [3:0] m, input int a);
		a = a % 4;
		if (a == 0) begin
			return m;
		end
		return 4'((m << a) | (m >> (4 - a)));
	endfunction

	function automatic int tuple_width();
		return (cfg.num_clusters_per_tuple == 0) ? 4 : int'(cfg.num_clusters_per_tuple);
	endfunction

	task automatic value_error(input string what, input logic [LINE_BITS-1:0] exp,
			input logic [LINE_BITS-1:0] act);
		$display("Error: %s %s expected %h actual %h", test_name, what, exp, act);
		test_errs++;
	endtask

	task automatic fail_note(input string msg);
		$display("test %s: %s", test_name, msg);
		test_errs++;
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		total_errs += test_errs;
		if (test_errs == 0) begin
			tests_ok++;
			$display("test %s: ok", test_name);
		end else begin
			tests_bad++;
			$display("test %s: failed with %0d errors", test_name, test_errs);
		end
	endtask

	function automatic core_line_t make_line(input bit data, input bit last);
		core_line_t l;
		l.word.raw   = {next_rand(), next_rand(), next_rand(), next_rand()};
		l.data_valid = data;
		l.last       = last;
		l.prog_mode  = !data;
		return l;
	endfunction

	// expected lane lines follow from the order in which lines enter the core
	task automatic model_accept(input core_line_t l);
		lane_line_t              e;
		logic [NUM_CLUSTERS-1:0] m;
		m = l.data_valid ? m_proc : m_prog;
		e = '{valid: l.data_valid, last: l.last, ctrl: 1'b0,
			mode: {l.prog_mode, l.data_valid}, pu: m_pu, word: l.word};
		for (int i = 0; i < NUM_CLUSTERS; i++) begin
			if (m[i]) begin
				exp_lane[i].push_back(e);
			end
		end
		if (l.last) begin
			m_pu++;
			if (l.data_valid) begin
				m_proc = rotate_left(m_proc, tuple_width());
			end else begin
				m_trees++;
				if (m_trees == PUS_PER_CLUSTER) begin
					m_trees = 0;
					m_prog  = rotate_left(m_prog, 1);
				end
			end
		end
	endtask

	task automatic send_line(input core_line_t l);
		bit acc;
		din       = l;
		din_valid = 1'b1;
		do begin
			acc = din_ready;
			@(posedge clk);
			#1;
		end while (!acc);
		din_valid = 1'b0;
		model_accept(l);
	endtask

	function automatic int lanes_pending();
		int n;
		n = 0;
		for (int i = 0; i < NUM_CLUSTERS; i++) begin
			n += exp_lane[i].size();
		end
		return n;
	endfunction

	task automatic wait_lanes(input int limit);
		int n;
		n = 0;
		while (lanes_pending() != 0 && n < limit) begin
			@(posedge clk);
			#1;
			n++;
		end
		assert (lanes_pending() == 0) else fail_note("lines still missing on the lanes");
	endtask

	task automatic wait_results(input int limit);
		int n;
		n = 0;
		while (exp_result.size() != 0 && n < limit) begin
			@(posedge clk);
			#1;
			n++;
		end
		assert (exp_result.size() == 0) else fail_note("tuple results still missing");
	endtask

	// each cluster of the tuple gets one partial, the sum wraps at 32 bits
	task automatic enqueue_tuple();
		logic [RESULT_WIDTH-1:0] v;
		logic [RESULT_WIDTH-1:0] sum;
		int                      base;
		base = (g_tuple * tuple_width()) % NUM_CLUSTERS;
		sum  = '0;
		for (int o = 0; o < tuple_width(); o++) begin
			v = next_rand();
			part_q[(base + o) % NUM_CLUSTERS].push_back(v);
			sum += v;
		end
		exp_result.push_back(sum);
		g_tuple++;
	endtask

	////////////////////////////////
	// monitors and cluster models
	////////////////////////////////

	always @(posedge clk) begin
		lane_line_t got;
		lane_line_t want;
		if (rst_n) begin
			for (int i = 0; i < NUM_CLUSTERS; i++) begin
				got = lane_out[i];
				if (got.ctrl) begin
					ctrl_seen[i]++;
					assert (!got.valid && got.word.params == ctrl_expect)
						else value_error("control line", ctrl_expect, got.word);
				end else if (got.valid || got.mode != 2'b00) begin
					assert (!(stalled && got.valid))
						else fail_note("tuple line delivered while a target lane was busy");
					if (exp_lane[i].size() == 0) begin
						fail_note($sformatf("unexpected line on lane %0d", i));
					end else begin
						want = exp_lane[i].pop_front();
						assert (got === want)
							else value_error($sformatf("lane %0d", i), want, got);
					end
				end
			end
		end
	end

	// partials, result consumer and lane readiness, driven just after the edge
	always @(posedge clk) begin
		logic [RESULT_WIDTH-1:0] want;
		if (rst_n) begin
			for (int i = 0; i < NUM_CLUSTERS; i++) begin
				if (part_valid[i] && part_ready[i]) begin
					void'(part_q[i].pop_front());
				end
			end
			assert (!(tuple_out_valid && part_ready != '0))
				else fail_note("part_ready high while a result is held");
			if (held && tuple_out_valid) begin
				assert (tuple_out_data == held_data)
					else value_error("held result", held_data, tuple_out_data);
			end
			held      = tuple_out_valid && !tuple_out_ready;
			held_data = tuple_out_data;
			if (held) begin
				hold_cycles++;
			end
			if (tuple_out_valid && tuple_out_ready) begin
				if (exp_result.size() == 0) begin
					fail_note("result appeared with no tuple expected");
				end else begin
					want = exp_result.pop_front();
					assert (tuple_out_data == want)
						else value_error("tuple sum", want, tuple_out_data);
				end
			end
		end
		#1;
		for (int i = 0; i < NUM_CLUSTERS; i++) begin
			part_valid[i] = (part_q[i].size() > 0) && (next_rand() % 3 != 0);
			part_value[i] = (part_q[i].size() > 0) ? part_q[i][0] : '0;
		end
		tuple_out_ready = !hold_result && (next_rand() % 4 != 0);
		lane_ready = hold_lanes ? stall_ready : (4'(next_rand()) | 4'(next_rand()));
	end

	initial begin
		#((40 * N_LINES + 200) * 8);
		$display("watchdog: the run did not finish within its time limit");
		$display("Result: FAILED");
		$finish;
	end

	////////////////////////////////
	// test sequence
	////////////////////////////////

	initial begin
		int s;
		int n;
		rst_n           = 1'b0;
		start_core      = 1'b0;
		din             = '0;
		din_valid       = 1'b0;
		lane_ready      = '0;
		part_valid      = '0;
		tuple_out_ready = 1'b0;
		for (int i = 0; i < NUM_CLUSTERS; i++) begin
			part_value[i] = '0;
			ctrl_seen[i]  = 0;
		end
		cfg.prog_schedule          = 4'b0011;
		cfg.proc_schedule          = 4'b0011;
		cfg.num_clusters_per_tuple = 2'd2;
		cfg.params                 = PARAM_BITS'({next_rand(), next_rand(), next_rand()});
		ctrl_expect = '{fields: cfg.params, pad: '0};
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;

		begin_test("config broadcast");
		assert (core_state == IDLE && !tuple_out_valid && part_ready == '0)
			else fail_note("outputs not idle after reset");
		m_prog     = cfg.prog_schedule;
		m_proc     = cfg.proc_schedule;
		start_core = 1'b1;
		@(posedge clk);
		#1;
		start_core = 1'b0;
		assert (core_state == CONFIG) else value_error("state", CONFIG, core_state);
		@(posedge clk);
		#1;
		assert (core_state == PROG) else value_error("state", PROG, core_state);
		@(posedge clk);
		#1;
		assert (!lane_out[0].ctrl) else fail_note("control line arrived early");
		@(posedge clk);
		#1;
		for (int i = 0; i < NUM_CLUSTERS; i++) begin
			assert (lane_out[i].ctrl) else fail_note("control line missing on a lane");
		end
		@(posedge clk);
		#1;
		for (int i = 0; i < NUM_CLUSTERS; i++) begin
			assert (ctrl_seen[i] == 1) else value_error("control count", 1, ctrl_seen[i]);
		end
		end_test();

		begin_test("program routing");
		for (int t = 0; t < 12; t++) begin
			send_line(make_line(1'b0, t % 2 == 1));
		end
		wait_lanes(400);
		end_test();

		begin_test("process routing");
		for (int t = 0; t < 16; t++) begin
			send_line(make_line(1'b1, t % 2 == 1));
		end
		wait_lanes(640);
		assert (core_state == PROCESS) else value_error("state", PROCESS, core_state);
		end_test();

		// stall the lowest lane of the mask that the next tuple will use
		begin_test("back-pressure");
		s = 0;
		while (!m_proc[s]) begin
			s++;
		end
		stall_ready = ~(4'b0001 << s);
		hold_lanes  = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		stalled = 1'b1;
		n = 0;
		while (din_ready && n < 20) begin
			send_line(make_line(1'b1, n % 2 == 1));
			n++;
		end
		assert (n == 16) else value_error("lines queued before ready fell", 16, n);
		repeat (10) @(posedge clk);
		#1;
		stalled    = 1'b0;
		hold_lanes = 1'b0;
		wait_lanes(640);
		end_test();

		begin_test("gather and sum");
		for (int t = 0; t < 6; t++) begin
			enqueue_tuple();
		end
		wait_results(480);
		end_test();

		begin_test("result hold");
		hold_result = 1'b1;
		for (int t = 0; t < 3; t++) begin
			enqueue_tuple();
		end
		n = 0;
		while (!tuple_out_valid && n < 200) begin
			@(posedge clk);
			#1;
			n++;
		end
		hold_cycles = 0;
		repeat (10) @(posedge clk);
		#1;
		hold_result = 1'b0;
		assert (hold_cycles >= 8) else value_error("held cycles", 8, hold_cycles);
		wait_results(400);
		end_test();

		$display("tests passed: %0d, failed: %0d", tests_ok, tests_bad);
		if (tests_bad == 0 && total_errs == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

//--- verilog/core_fsm.sv
module core_fsm
	import dt_core_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        start_core,
	input  logic        head_valid,
	input  logic        head_is_data,
	output core_state_e state,
	output logic        cfg_strobe
);

	////////////////////////////////
	// state sequence
	////////////////////////////////

	// start_core restarts the sequence from any state, so the cycle after
	// the pulse is always the single CONFIG cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
		end else if (start_core) begin
			state <= CONFIG;
		end else begin
			case (state)
				IDLE: begin
					state <= IDLE;
				end
				CONFIG: begin
					state <= PROG;
				end
				PROG: begin
					// programming ends when the first tuple line reaches the head
					if (head_valid && head_is_data) begin
						state <= PROCESS;
					end
				end
				PROCESS: begin
					state <= PROCESS;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// the control line is launched into the fan-out tree during CONFIG
	assign cfg_strobe = (state == CONFIG);

endmodule

//--- verilog/distribution_tree.sv
module distribution_tree
	import dt_core_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst_n,
	input  core_line_t              head,
	input  logic                    pop,
	input  logic [NUM_CLUSTERS-1:0] lane_mask,
	input  logic [PU_BITS-1:0]      pu,
	input  logic                    cfg_strobe,
	input  engine_params_t          params,
	output lane_line_t              lanes [NUM_CLUSTERS]
);

	// level l uses nodes 0 to 2**l - 1, each node carries its lane mask along
	lane_line_t              node [DISTR_LEVELS+1][NUM_CLUSTERS];
	logic [NUM_CLUSTERS-1:0] en   [DISTR_LEVELS+1][NUM_CLUSTERS];

	////////////////////////////////
	// stage 0
	////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			node[0][0].valid <= 1'b0;
			node[0][0].last  <= 1'b0;
			node[0][0].ctrl  <= 1'b0;
			node[0][0].mode  <= '0;
			en[0][0]         <= '0;
		end else if (cfg_strobe) begin
			// the control line reaches every lane and carries no data valid
			node[0][0].valid       <= 1'b0;
			node[0][0].last        <= 1'b0;
			node[0][0].ctrl        <= 1'b1;
			node[0][0].mode        <= '0;
			node[0][0].pu          <= '0;
			node[0][0].word.params <= params;
			en[0][0]               <= '1;
		end else if (pop) begin
			node[0][0].valid <= head.data_valid;
			node[0][0].last  <= head.last;
			node[0][0].ctrl  <= 1'b0;
			node[0][0].mode  <= {head.prog_mode, head.data_valid};
			node[0][0].pu    <= pu;
			node[0][0].word  <= head.word;
			en[0][0]         <= lane_mask;
		end else begin
			node[0][0].valid <= 1'b0;
			node[0][0].last  <= 1'b0;
			node[0][0].ctrl  <= 1'b0;
			node[0][0].mode  <= '0;
		end
	end

	////////////////////////////////
	// fan-out levels and leaves
	////////////////////////////////

	for (genvar l = 0; l < DISTR_LEVELS; l++) begin : g_level
		for (genvar j = 0; j < (2 << l); j++) begin : g_node
			always_ff @(posedge clk) begin
				node[l+1][j].word <= node[l][j>>1].word;
				node[l+1][j].pu   <= node[l][j>>1].pu;
				if (!rst_n) begin
					node[l+1][j].valid <= 1'b0;
					node[l+1][j].last  <= 1'b0;
					node[l+1][j].ctrl  <= 1'b0;
					node[l+1][j].mode  <= '0;
					en[l+1][j]         <= '0;
				end else begin
					node[l+1][j].valid <= node[l][j>>1].valid;
					node[l+1][j].last  <= node[l][j>>1].last;
					node[l+1][j].ctrl  <= node[l][j>>1].ctrl;
					node[l+1][j].mode  <= node[l][j>>1].mode;
					en[l+1][j]         <= en[l][j>>1];
				end
			end
		end
	end

	// a lane outside the mask sees the word but no valid, last or mode
	for (genvar i = 0; i < NUM_CLUSTERS; i++) begin : g_lane
		assign lanes[i] = '{
			valid: node[DISTR_LEVELS][i].valid & en[DISTR_LEVELS][i][i],
			last:  node[DISTR_LEVELS][i].last & en[DISTR_LEVELS][i][i],
			ctrl:  node[DISTR_LEVELS][i].ctrl,
			mode:  node[DISTR_LEVELS][i].mode & {2{en[DISTR_LEVELS][i][i]}},
			pu:    node[DISTR_LEVELS][i].pu,
			word:  node[DISTR_LEVELS][i].word
		};
	end

endmodule

//--- verilog/dt_core.sv
module dt_core
	import dt_core_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    start_core,
	input  core_line_t              core_data_in,
	input  logic                    core_data_in_valid,
	output logic                    core_data_in_ready,
	input  core_cfg_t               cfg,
	output lane_line_t              lane_out [NUM_CLUSTERS],
	input  logic [NUM_CLUSTERS-1:0] lane_ready,
	input  logic [RESULT_WIDTH-1:0] part_value [NUM_CLUSTERS],
	input  logic [NUM_CLUSTERS-1:0] part_valid,
	output logic [NUM_CLUSTERS-1:0] part_ready,
	output logic [RESULT_WIDTH-1:0] tuple_out_data,
	output logic                    tuple_out_valid,
	input  logic                    tuple_out_ready,
	output core_state_e             core_state
);

	core_line_t              fifo_head;
	logic                    fifo_valid;
	logic                    fifo_full;
	logic                    pop;
	logic [NUM_CLUSTERS-1:0] lane_mask;
	logic [PU_BITS-1:0]      pu;
	logic                    cfg_strobe;
	engine_params_t          ctrl_params;

	assign core_data_in_ready = !fifo_full;

	// the control line is the configured parameters with a zero pad
	assign ctrl_params = '{fields: cfg.params, pad: '0};

	line_fifo u_fifo (
		.clk   (clk),
		.rst_n (rst_n),
		.din   (core_data_in),
		.wr    (core_data_in_valid),
		.rd    (pop),
		.dout  (fifo_head),
		.valid (fifo_valid),
		.full  (fifo_full)
	);

	core_fsm u_fsm (
		.clk          (clk),
		.rst_n        (rst_n),
		.start_core   (start_core),
		.head_valid   (fifo_valid),
		.head_is_data (fifo_head.data_valid),
		.state        (core_state),
		.cfg_strobe   (cfg_strobe)
	);

	schedule_rotator u_rotator (
		.clk        (clk),
		.rst_n      (rst_n),
		.start_core (start_core),
		.state      (core_state),
		.cfg        (cfg),
		.head       (fifo_head),
		.head_valid (fifo_valid),
		.lane_ready (lane_ready),
		.pop        (pop),
		.lane_mask  (lane_mask),
		.pu         (pu)
	);

	distribution_tree u_tree (
		.clk        (clk),
		.rst_n      (rst_n),
		.head       (fifo_head),
		.pop        (pop),
		.lane_mask  (lane_mask),
		.pu         (pu),
		.cfg_strobe (cfg_strobe),
		.params     (ctrl_params),
		.lanes      (lane_out)
	);

	result_gather u_gather (
		.clk                (clk),
		.rst_n              (rst_n),
		.start_core         (start_core),
		.clusters_per_tuple (cfg.num_clusters_per_tuple),
		.part_value         (part_value),
		.part_valid         (part_valid),
		.part_ready         (part_ready),
		.result             (tuple_out_data),
		.result_valid       (tuple_out_valid),
		.result_ready       (tuple_out_ready)
	);

endmodule

//--- verilog/dt_core_pkg.sv
package dt_core_pkg;

	////////////////////////////////
	// sizes
	////////////////////////////////

	localparam int NUM_CLUSTERS    = 4;
	localparam int CLUSTER_BITS    = 2;
	localparam int DISTR_LEVELS    = 2;
	localparam int PUS_PER_CLUSTER = 2;
	localparam int PU_BITS         = 3;
	localparam int DATA_BUS_WIDTH  = 128;
	localparam int RESULT_WIDTH    = 32;
	localparam int FIFO_DEPTH_BITS = 4;

	typedef enum logic [1:0] {
		IDLE,
		CONFIG,
		PROG,
		PROCESS
	} core_state_e;

	////////////////////////////////
	// engine parameters and lines
	////////////////////////////////

	// the 92 meaningful bits that every cluster needs before programming
	typedef struct packed {
		logic [15:0] tuple_numcls;
		logic [31:0] missing_value;
		logic [15:0] tree_feature_index_numcls;
		logic [15:0] tree_weights_numcls;
		logic [3:0]  num_levels_per_tree;
		logic [7:0]  num_trees_per_pu;
	} params_fields_t;

	localparam int PARAMS_PAD_BITS = DATA_BUS_WIDTH - $bits(params_fields_t);

	// control line layout, padded with zeros up to a full line word
	typedef struct packed {
		params_fields_t              fields;
		logic [PARAMS_PAD_BITS-1:0]  pad;
	} engine_params_t;

	// a line word is raw tuple or tree data, except on the control line
	typedef union packed {
		logic [DATA_BUS_WIDTH-1:0] raw;
		engine_params_t            params;
	} line_word_u;

	typedef struct packed {
		line_word_u word;
		logic       data_valid;
		logic       last;
		logic       prog_mode;
	} core_line_t;

	// mode is {prog_mode, data_valid} of the line that was popped
	typedef struct packed {
		logic               valid;
		logic               last;
		logic               ctrl;
		logic [1:0]         mode;
		logic [PU_BITS-1:0] pu;
		line_word_u         word;
	} lane_line_t;

	// num_clusters_per_tuple of zero stands for all four clusters
	typedef struct packed {
		logic [NUM_CLUSTERS-1:0] prog_schedule;
		logic [NUM_CLUSTERS-1:0] proc_schedule;
		logic [CLUSTER_BITS-1:0] num_clusters_per_tuple;
		params_fields_t          params;
	} core_cfg_t;

endpackage

//--- verilog/line_fifo.sv
module line_fifo
	import dt_core_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  core_line_t din,
	input  logic       wr,
	input  logic       rd,
	output core_line_t dout,
	output logic       valid,
	output logic       full
);

	localparam int DEPTH = 2 ** FIFO_DEPTH_BITS;

	core_line_t                 mem [DEPTH];
	logic [FIFO_DEPTH_BITS-1:0] wr_ptr;
	logic [FIFO_DEPTH_BITS-1:0] rd_ptr;
	logic [FIFO_DEPTH_BITS:0]   count;
	logic                       do_wr;
	logic                       do_rd;

	assign valid = (count != '0);
	assign full  = (count == (FIFO_DEPTH_BITS + 1)'(DEPTH));

	// writes into a full buffer and reads from an empty one are dropped
	assign do_wr = wr && !full;
	assign do_rd = rd && valid;

	// the head is shown straight from the buffer so it can be popped at once
	assign dout = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (do_wr && !do_rd) begin
				count <= count + 1'b1;
			end else if (do_rd && !do_wr) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

//--- verilog/result_gather.sv
module result_gather
	import dt_core_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    start_core,
	input  logic [CLUSTER_BITS-1:0] clusters_per_tuple,
	input  logic [RESULT_WIDTH-1:0] part_value [NUM_CLUSTERS],
	input  logic [NUM_CLUSTERS-1:0] part_valid,
	output logic [NUM_CLUSTERS-1:0] part_ready,
	output logic [RESULT_WIDTH-1:0] result,
	output logic                    result_valid,
	input  logic                    result_ready
);

	logic                    active;
	logic [CLUSTER_BITS-1:0] base;
	logic [CLUSTER_BITS-1:0] offset;
	logic [CLUSTER_BITS-1:0] cur;
	logic [RESULT_WIDTH-1:0] acc;
	logic [RESULT_WIDTH-1:0] sum;
	logic                    take;
	logic                    last_part;

	// the tuple's clusters follow each other from base, wrapping past lane 3
	assign cur = base + offset;

	// a count of zero wraps to three here, so four clusters are gathered
	assign last_part = (offset == CLUSTER_BITS'(clusters_per_tuple - 1'b1));

	assign sum = acc + part_value[cur];

	////////////////////////////////
	// partial selection
	////////////////////////////////

	// only the current cluster is offered a slot and nobody while a result waits
	always_comb begin
		for (int i = 0; i < NUM_CLUSTERS; i++) begin
			part_ready[i] = active && !result_valid && (cur == CLUSTER_BITS'(i));
		end
	end

	assign take = |(part_valid & part_ready);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			active       <= 1'b0;
			result_valid <= 1'b0;
			base         <= '0;
			offset       <= '0;
			acc          <= '0;
		end else if (start_core) begin
			active       <= 1'b1;
			result_valid <= 1'b0;
			base         <= '0;
			offset       <= '0;
			acc          <= '0;
		end else begin
			// the next tuple starts where this one's clusters ended
			if (result_valid && result_ready) begin
				result_valid <= 1'b0;
				base         <= base + clusters_per_tuple;
			end
			if (take) begin
				if (last_part) begin
					result_valid <= 1'b1;
					offset       <= '0;
					acc          <= '0;
				end else begin
					offset <= offset + 1'b1;
					acc    <= sum;
				end
			end
		end
	end

	////////////////////////////////
	// tuple result
	////////////////////////////////

	always_ff @(posedge clk) begin
		if (take && last_part) begin
			result <= sum;
		end
	end

endmodule

//--- verilog/schedule_rotator.sv
module schedule_rotator
	import dt_core_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    start_core,
	input  core_state_e             state,
	input  core_cfg_t               cfg,
	input  core_line_t              head,
	input  logic                    head_valid,
	input  logic [NUM_CLUSTERS-1:0] lane_ready,
	output logic                    pop,
	output logic [NUM_CLUSTERS-1:0] lane_mask,
	output logic [PU_BITS-1:0]      pu
);

	logic [NUM_CLUSTERS-1:0] prog_mask;
	logic [NUM_CLUSTERS-1:0] proc_mask;
	logic [PU_BITS-1:0]      tree_cnt;
	logic                    is_data;
	logic                    targets_ready;
	logic                    tree_step;

	// rotate towards the higher lane index, bits leaving the top wrap to lane 0
	function automatic logic [NUM_CLUSTERS-1:0] rotl(
		input logic [NUM_CLUSTERS-1:0] mask,
		input logic [CLUSTER_BITS-1:0] amount
	);
		logic [2*NUM_CLUSTERS-1:0] dbl;
		dbl = {mask, mask} << amount;
		return dbl[2*NUM_CLUSTERS-1 -: NUM_CLUSTERS];
	endfunction

	assign is_data   = head.data_valid;
	assign lane_mask = is_data ? proc_mask : prog_mask;
	assign tree_step = (tree_cnt == PU_BITS'(PUS_PER_CLUSTER - 1));

	// a tuple line waits until every lane it targets can take it
	assign targets_ready = &(lane_ready | ~proc_mask);

	always_comb begin
		pop = 1'b0;
		if (head_valid && !start_core) begin
			if (is_data) begin
				pop = (state == PROCESS) && targets_ready;
			end else begin
				pop = (state == PROG) || (state == PROCESS);
			end
		end
	end

	////////////////////////////////
	// masks and counters
	////////////////////////////////

	// a new mask applies from the line after the one that ended the step
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			prog_mask <= '0;
			proc_mask <= '0;
			tree_cnt  <= '0;
			pu        <= '0;
		end else if (start_core) begin
			prog_mask <= cfg.prog_schedule;
			proc_mask <= cfg.proc_schedule;
			tree_cnt  <= '0;
			pu        <= '0;
		end else if (pop && head.last) begin
			pu <= pu + 1'b1;
			if (is_data) begin
				proc_mask <= rotl(proc_mask, cfg.num_clusters_per_tuple);
			end else if (tree_step) begin
				prog_mask <= rotl(prog_mask, CLUSTER_BITS'(1));
				tree_cnt  <= '0;
			end else begin
				tree_cnt <= tree_cnt + 1'b1;
			end
		end
	end

endmodule
